/* ss_defs.svh */
`ifndef SS_DEFS_SVH
`define SS_DEFS_SVH

// Width of one data word on the wide register bus
`define SS_DATA_WIDTH 16

// Width of a register bus address
`define SS_BUS_WIDTH 8

// Width of one word in the narrow memory
`define MEM_DATA_WIDTH 4

// Memory words that make up one bus word
`define WORDS_PER_BUS 4

// Word counter width, one bit wider than needed so it can reach WORDS_PER_BUS
`define WORD_IDX_WIDTH 3

// Memory address is the window offset joined with the word select bits
`define MEM_ADDR_WIDTH 6

// Window in the bus address map, MAX is the first address past the window
`define WINDOW_MIN 8'h20
`define WINDOW_MAX 8'h30

`endif

/* ss_pkg.sv */
`include "ss_defs.svh"

package ss_pkg;

  // One word as seen on the register bus
  typedef logic [`SS_DATA_WIDTH-1:0] ss_data_t;

  // Register bus address
  typedef logic [`SS_BUS_WIDTH-1:0] ss_addr_t;

  // One word of the narrow memory
  typedef logic [`MEM_DATA_WIDTH-1:0] mem_word_t;

  // Narrow memory address, window offset in the upper bits and word select below
  typedef logic [`MEM_ADDR_WIDTH-1:0] mem_addr_t;

  // Word counter, the top bit marks a fully fetched read
  typedef logic [`WORD_IDX_WIDTH-1:0] word_idx_t;

  // The sequencer is either waiting for a new address or moving words
  typedef enum logic {
    seq_idle,
    seq_busy
  } seq_state_t;

endpackage

/* mem_port_if.sv */
`timescale 1ns/1ps

interface mem_port_if;

  // Address of the memory word being accessed
  ss_pkg::mem_addr_t mem_addr;

  // Word to be written, taken from the bottom of the shift buffer
  ss_pkg::mem_word_t mem_new_data;

  // Write enable, high for the four write cycles of a transfer
  logic mem_wren;

  // Word stored at mem_addr
  ss_pkg::mem_word_t mem_current_data;

  // The datapaths and the sequencer each drive their own part of this side
  modport master (
    output mem_addr,
    output mem_new_data,
    output mem_wren,
    input  mem_current_data
  );

  // Memory array side
  modport ram (
    input  mem_addr,
    input  mem_new_data,
    input  mem_wren,
    output mem_current_data
  );

endinterface

/* seq_ctl_if.sv */
`timescale 1ns/1ps

interface seq_ctl_if;

  // One-cycle strobes from the sequencer
  logic offset_clear;
  logic offset_step;
  logic buf_load;
  logic buf_shift;

  // Status returned by the address generator
  ss_pkg::word_idx_t word_offset;
  logic in_window;

  modport sequencer (
    output offset_clear,
    output offset_step,
    output buf_load,
    output buf_shift,
    input  word_offset,
    input  in_window
  );

  // The address generator owns the word counter and the window decode
  modport addr_gen (
    input  offset_clear,
    input  offset_step,
    output word_offset,
    output in_window
  );

  modport buffer (
    input buf_load,
    input buf_shift
  );

endinterface

/* mem_address_gen.sv */
`timescale 1ns/1ps
`include "ss_defs.svh"

module mem_address_gen (
  input  logic              clk,
  input  logic              arst_n,
  input  ss_pkg::ss_addr_t  bus_addr,
  seq_ctl_if.addr_gen       ctl,
  mem_port_if.master        mem
);

  logic in_window;

  // Bus address relative to the window base
  ss_pkg::ss_addr_t window_offset;

  // Word counter, cleared and stepped by the sequencer
  ss_pkg::word_idx_t word_offset;

  // The window is half open, WINDOW_MAX itself lies outside
  assign in_window = (bus_addr >= `WINDOW_MIN) && (bus_addr < `WINDOW_MAX);

  // Outside the window the offset is forced to zero so the memory address stays quiet
  always_comb begin
    if (in_window) begin
      window_offset = bus_addr - ss_pkg::ss_addr_t'(`WINDOW_MIN);
    end else begin
      window_offset = '0;
    end
  end

  // Clear has priority so an abort always lands on word zero
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      word_offset <= '0;
    end else if (ctl.offset_clear) begin
      word_offset <= '0;
    end else if (ctl.offset_step) begin
      word_offset <= word_offset + 1'b1;
    end
  end

  // Only the low counter bits select the word; the extra top bit wraps back to word 0
  assign mem.mem_addr = {
    window_offset[`MEM_ADDR_WIDTH-`WORD_IDX_WIDTH:0],
    word_offset[`WORD_IDX_WIDTH-2:0]
  };

  // Status back to the sequencer
  assign ctl.word_offset = word_offset;
  assign ctl.in_window   = in_window;

endmodule

/* word_shift_buffer.sv */
`timescale 1ns/1ps
`include "ss_defs.svh"

module word_shift_buffer (
  input  logic              clk,
  input  logic              arst_n,
  input  ss_pkg::ss_data_t  bus_in,
  output ss_pkg::ss_data_t  bus_out,
  seq_ctl_if.buffer         ctl,
  mem_port_if.master        mem
);

  // Holds the bus word for the whole transfer
  ss_pkg::ss_data_t buffer;

  // A load takes the bus word at the start of a write.
  // Every shift moves the buffer down by one memory word and puts the word
  // read from memory at the top.
  // For a write the bottom word is what goes to memory, so shifting walks
  // through the bus word from the lowest word upwards.
  // For a read four shifts fill the buffer from the top, so the first word
  // fetched ends up at the bottom.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      buffer <= '0;
    end else if (ctl.buf_load) begin
      buffer <= bus_in;
    end else if (ctl.buf_shift) begin
      buffer <= {mem.mem_current_data, buffer[`SS_DATA_WIDTH-1:`MEM_DATA_WIDTH]};
    end
  end

  // Write data is always the lowest word
  assign mem.mem_new_data = buffer[`MEM_DATA_WIDTH-1:0];

  // Bus read data comes straight from the buffer
  assign bus_out = buffer;

endmodule

/* narrow_ram.sv */
`timescale 1ns/1ps
`include "ss_defs.svh"

module narrow_ram (
  input  logic    clk,
  mem_port_if.ram mem
);

  // One entry per memory address, 16 window slots of 4 words each
  ss_pkg::mem_word_t mem_array [0:(1 << `MEM_ADDR_WIDTH)-1];

  // Writes land on the rising edge while the enable is high
  always_ff @(posedge clk) begin
    if (mem.mem_wren) begin
      mem_array[mem.mem_addr] <= mem.mem_new_data;
    end
  end

  // Read data follows the address in the same cycle
  assign mem.mem_current_data = mem_array[mem.mem_addr];

endmodule

/* word_sequencer.sv */
`timescale 1ns/1ps
`include "ss_defs.svh"

module word_sequencer (
  input  logic              clk,
  input  logic              arst_n,
  input  ss_pkg::ss_addr_t  bus_addr,
  input  logic              bus_wren,
  seq_ctl_if.sequencer      ctl,
  mem_port_if.master        mem
);

  ss_pkg::seq_state_t state;

  // Direction of the running transfer, high for a write
  logic is_writing;

  // Address of the last transfer that was started
  ss_pkg::ss_addr_t last_addr;

  logic wren;

  // A transfer starts only on an in-window address not yet processed
  logic start;

  // High in the final cycle of a running transfer
  logic last_step;

  assign start = (state == ss_pkg::seq_idle) && ctl.in_window && (bus_addr != last_addr);

  // A write ends after its fourth word is written.
  // A read has already stepped once at the start, so it ends when the counter wraps to four.
  assign last_step = is_writing ? (ctl.word_offset == `WORDS_PER_BUS - 1) :
                                  (ctl.word_offset == `WORDS_PER_BUS);

  always_comb begin
    ctl.offset_clear = 1'b0;
    ctl.offset_step  = 1'b0;
    ctl.buf_load     = 1'b0;
    ctl.buf_shift    = 1'b0;
    if (!ctl.in_window) begin
      // Leaving the window drops whatever was in progress
      ctl.offset_clear = 1'b1;
    end else if (state == ss_pkg::seq_idle) begin
      if (start && bus_wren) begin
        // The address already points at word 0, so only the data is needed
        ctl.buf_load = 1'b1;
      end else if (start) begin
        // Word 0 is on the read port now; take it and move to the next one
        ctl.offset_step = 1'b1;
        ctl.buf_shift   = 1'b1;
      end
    end else begin
      if (last_step) begin
        ctl.offset_clear = 1'b1;
      end else begin
        ctl.offset_step = 1'b1;
      end
      // At count four a read has wrapped to word 0 again, which it already holds
      ctl.buf_shift = is_writing || (ctl.word_offset != `WORDS_PER_BUS);
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state      <= ss_pkg::seq_idle;
      is_writing <= 1'b0;
      last_addr  <= '0;
      wren       <= 1'b0;
    end else if (!ctl.in_window) begin
      state <= ss_pkg::seq_idle;
      wren  <= 1'b0;
    end else if (state == ss_pkg::seq_idle) begin
      if (start) begin
        state      <= ss_pkg::seq_busy;
        is_writing <= bus_wren;
        last_addr  <= bus_addr;
        // Write enable stays up from the first word to the last
        wren       <= bus_wren;
      end
    end else if (last_step) begin
      state <= ss_pkg::seq_idle;
      wren  <= 1'b0;
    end
  end

  assign mem.mem_wren = wren;

endmodule

/* bus_memory_top.sv */
`timescale 1ns/1ps
`include "ss_defs.svh"

module bus_memory_top (
  input  logic                      clk,
  input  logic                      arst_n,
  input  logic [`SS_DATA_WIDTH-1:0] bus_in,
  input  logic [`SS_BUS_WIDTH-1:0]  bus_addr,
  input  logic                      bus_wren,
  output logic [`SS_DATA_WIDTH-1:0] bus_out,
  output logic                      mem_active
);

  // Narrow memory port shared by the datapaths and the array
  mem_port_if mem_bus ();

  // Strobes and status between the sequencer and the datapaths
  seq_ctl_if ctl_bus ();

  // Window decode and memory address
  mem_address_gen u_addr_gen (
    .clk      (clk),
    .arst_n   (arst_n),
    .bus_addr (bus_addr),
    .ctl      (ctl_bus),
    .mem      (mem_bus)
  );

  // Holds the bus word and serializes it
  word_shift_buffer u_shift_buffer (
    .clk     (clk),
    .arst_n  (arst_n),
    .bus_in  (bus_in),
    .bus_out (bus_out),
    .ctl     (ctl_bus),
    .mem     (mem_bus)
  );

  narrow_ram u_ram (
    .clk (clk),
    .mem (mem_bus)
  );

  // Starts, steps and ends each transfer
  word_sequencer u_sequencer (
    .clk      (clk),
    .arst_n   (arst_n),
    .bus_addr (bus_addr),
    .bus_wren (bus_wren),
    .ctl      (ctl_bus),
    .mem      (mem_bus)
  );

  // The block claims the bus whenever the address is in its window
  assign mem_active = ctl_bus.in_window;

endmodule

/* tb_bus_memory_tasks.svh */
`ifndef TB_BUS_MEMORY_TASKS_SVH
`define TB_BUS_MEMORY_TASKS_SVH

// Value last written to each window slot, as a bus word
logic [`SS_DATA_WIDTH-1:0] shadow [0:WINDOW_SLOTS-1];

// Set once a slot holds a value that a read can be compared against
logic shadow_valid [0:WINDOW_SLOTS-1];

// Address the DUT treats as already processed
logic [`SS_BUS_WIDTH-1:0] last_done;

// Read check request handed from the tasks to the compare process
logic                      read_check;
logic [`SS_DATA_WIDTH-1:0] read_expected;
logic [`SS_BUS_WIDTH-1:0]  read_addr;

// Window slot of a bus address
function automatic logic [3:0] slot_of(input logic [`SS_BUS_WIDTH-1:0] addr);
  logic [`SS_BUS_WIDTH-1:0] diff;
  diff = addr - `WINDOW_MIN;
  return diff[3:0];
endfunction

// A read returns the last complete write to the same slot
function automatic logic [`SS_DATA_WIDTH-1:0] expected_read(input logic [3:0] slot);
  return shadow[slot];
endfunction

// An address is inside when its distance above the window base is less than the slot count.
// Addresses below the base wrap around to a large distance.
function automatic logic expected_active(input logic [`SS_BUS_WIDTH-1:0] addr);
  logic [`SS_BUS_WIDTH-1:0] diff;
  diff = addr - `WINDOW_MIN;
  return diff < WINDOW_SLOTS;
endfunction

task automatic start_access(input logic [`SS_BUS_WIDTH-1:0] addr, input logic wren,
                            input logic [`SS_DATA_WIDTH-1:0] data);
  @(negedge clk);
  bus_addr = addr;
  bus_wren = wren;
  bus_in   = data;
endtask

// One cycle outside the window returns the sequencer to idle
task automatic leave_window();
  @(negedge clk);
  bus_addr = OUTSIDE_ADDR;
  bus_wren = 1'b0;
  @(posedge clk);
endtask

task automatic run_read(input logic [`SS_BUS_WIDTH-1:0] addr, input logic do_check);
  start_access(addr, 1'b0, bus_in);
  // Edge E and four more edges until the word sits in the buffer
  repeat (`WORDS_PER_BUS + 1) @(posedge clk);
  last_done = addr;
  if (do_check) begin
    read_expected = expected_read(slot_of(addr));
    read_addr     = addr;
    read_check    = 1'b1;
  end
  leave_window();
endtask

// The DUT ignores the address it processed last, so another slot is read first
task automatic clear_repeat_block(input logic [`SS_BUS_WIDTH-1:0] addr);
  logic [`SS_BUS_WIDTH-1:0] other;
  if (addr == last_done) begin
    other = addr ^ 8'h01;
    run_read(other, shadow_valid[slot_of(other)]);
  end
endtask

task automatic read_word(input logic [`SS_BUS_WIDTH-1:0] addr);
  clear_repeat_block(addr);
  run_read(addr, 1'b1);
endtask

// Write that stays on the address afterwards
task automatic drive_write(input logic [`SS_BUS_WIDTH-1:0] addr,
                           input logic [`SS_DATA_WIDTH-1:0] data);
  clear_repeat_block(addr);
  start_access(addr, 1'b1, data);
  // Words 0 to 3 land at edges E+1 to E+4
  repeat (`WORDS_PER_BUS + 1) @(posedge clk);
  shadow[slot_of(addr)]       = data;
  shadow_valid[slot_of(addr)] = 1'b1;
  last_done                   = addr;
endtask

task automatic write_word(input logic [`SS_BUS_WIDTH-1:0] addr,
                          input logic [`SS_DATA_WIDTH-1:0] data);
  drive_write(addr, data);
  leave_window();
endtask

// One cycle on an address, then out again
task automatic probe_address(input logic [`SS_BUS_WIDTH-1:0] addr);
  @(negedge clk);
  bus_addr = addr;
  bus_wren = 1'b0;
  @(posedge clk);
  // An in-window address that is new starts a read and becomes the processed one
  if (expected_active(addr) && (addr != last_done)) begin
    last_done = addr;
  end
  leave_window();
endtask

`endif

/* tb_bus_memory.sv */
`timescale 1ns/1ps
`include "ss_defs.svh"

module tb_bus_memory;

  localparam int CLK_PERIOD    = 20;
  localparam int RESET_CYCLES  = 8;
  localparam int WINDOW_SLOTS  = `WINDOW_MAX - `WINDOW_MIN;
  localparam logic [`SS_BUS_WIDTH-1:0] OUTSIDE_ADDR = 8'h00;

  // Upper bound on bus accesses in the whole run, each one takes at most 8 cycles
  localparam int ACCESS_COUNT   = 90;
  localparam int MARGIN_CYCLES  = 50;
  localparam int TIMEOUT_CYCLES = ACCESS_COUNT * 8 + RESET_CYCLES + MARGIN_CYCLES;

  logic                      clk;
  logic                      arst_n;
  logic [`SS_DATA_WIDTH-1:0] bus_in;
  logic [`SS_BUS_WIDTH-1:0]  bus_addr;
  logic                      bus_wren;
  logic [`SS_DATA_WIDTH-1:0] bus_out;
  logic                      mem_active;

  int error_count;
  int check_count;
  integer seed;

  // Read order for the second pass over the window
  int order [0:WINDOW_SLOTS-1];
  int i;
  int j;
  int tmp;

  logic [`SS_BUS_WIDTH-1:0]  addr;
  logic [`SS_DATA_WIDTH-1:0] data;
  logic [`SS_DATA_WIDTH-1:0] other_data;

  `include "tb_bus_memory_tasks.svh"

  bus_memory_top UUT (
    .clk        (clk),
    .arst_n     (arst_n),
    .bus_in     (bus_in),
    .bus_addr   (bus_addr),
    .bus_wren   (bus_wren),
    .bus_out    (bus_out),
    .mem_active (mem_active)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Outputs are sampled a quarter period after the rising edge, well away from the drive edge
  always @(posedge clk) begin
    #(CLK_PERIOD / 4);
    if (arst_n) begin
      check_count++;
      assert (mem_active === expected_active(bus_addr)) else begin
        error_count++;
        $display("FAILED at %0t: mem_active expected %0b, got %0b (bus_addr %h)",
                 $time, expected_active(bus_addr), mem_active, bus_addr);
      end
      if (read_check) begin
        check_count++;
        assert (bus_out === read_expected) else begin
          error_count++;
          $display("FAILED at %0t: bus_out expected %h, got %h (bus_addr %h)",
                   $time, read_expected, bus_out, read_addr);
        end
        read_check = 1'b0;
      end
    end
  end

  // Ends a run that stops making progress
  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("Timeout: the tests did not finish within %0d clock cycles", TIMEOUT_CYCLES);
    $display("Simulation failed");
    $finish;
  end

  initial begin
    seed          = 47;
    error_count   = 0;
    check_count   = 0;
    arst_n        = 1'b0;
    bus_in        = '0;
    bus_addr      = OUTSIDE_ADDR;
    bus_wren      = 1'b0;
    read_check    = 1'b0;
    read_expected = '0;
    read_addr     = '0;
    last_done     = '0;
    for (i = 0; i < WINDOW_SLOTS; i++) begin
      shadow[i]       = '0;
      shadow_valid[i] = 1'b0;
    end

    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;

    // Window decode at both limits and on either side
    probe_address(8'h00);
    probe_address(8'h1F);
    probe_address(8'h20);
    probe_address(8'h21);
    probe_address(8'h2F);
    probe_address(8'h30);
    probe_address(8'h31);
    probe_address(8'hFF);
    for (i = 0; i < 4; i++) begin
      addr = $random(seed);
      probe_address(addr);
    end

    // Fill every slot of the window
    for (i = 0; i < WINDOW_SLOTS; i++) begin
      data = $random(seed);
      write_word(`WINDOW_MIN + i, data);
    end

    // Read the window back in a shuffled order
    for (i = 0; i < WINDOW_SLOTS; i++) begin
      order[i] = i;
    end
    for (i = WINDOW_SLOTS - 1; i > 0; i--) begin
      j        = {$random(seed)} % (i + 1);
      tmp      = order[i];
      order[i] = order[j];
      order[j] = tmp;
    end
    for (i = 0; i < WINDOW_SLOTS; i++) begin
      read_word(`WINDOW_MIN + order[i]);
    end

    // Overwrite one slot, its neighbours keep their contents
    data = ~shadow[slot_of(8'h27)];
    write_word(8'h27, data);
    read_word(8'h27);
    read_word(8'h26);
    read_word(8'h28);

    // A second write to the same address without leaving it is ignored
    data       = $random(seed);
    other_data = ~data;
    drive_write(8'h2B, data);
    @(negedge clk);
    bus_in = other_data;
    repeat (`WORDS_PER_BUS + 1) @(posedge clk);
    leave_window();
    read_word(8'h2B);

    // Abort a write two edges after it started
    data = $random(seed);
    clear_repeat_block(8'h2D);
    start_access(8'h2D, 1'b1, data);
    repeat (3) @(posedge clk);
    leave_window();
    last_done = 8'h2D;
    // The aborted slot is half written, and the leaving cycle can still write through slot 0
    shadow_valid[slot_of(8'h2D)] = 1'b0;
    shadow_valid[0]              = 1'b0;
    #(CLK_PERIOD / 4);
    check_count++;
    assert (UUT.mem_bus.mem_wren === 1'b0) else begin
      error_count++;
      $display("FAILED at %0t: mem_wren expected 0, got %0b", $time, UUT.mem_bus.mem_wren);
    end

    // The next complete write to the same slot must be intact
    data = $random(seed);
    write_word(8'h2D, data);
    read_word(8'h2D);

    repeat (2) @(posedge clk);
    $display("Checks run: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* sim.f */
+incdir+.
ss_pkg.sv
mem_port_if.sv
seq_ctl_if.sv
mem_address_gen.sv
word_shift_buffer.sv
narrow_ram.sv
word_sequencer.sv
bus_memory_top.sv
tb_bus_memory.sv
